// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns
TOP       := core_tb
FILELIST  := riscv_core.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh test/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    input  core_pkg::alu_op_t op,
    output core_pkg::word_t   result,
    output logic              zero
);

    always_comb begin
        case (op)
            core_pkg::ALU_ADD: result = a + b;
            core_pkg::ALU_SUB: result = a - b;
            core_pkg::ALU_AND: result = a & b;
            core_pkg::ALU_OR:  result = a | b;
            core_pkg::ALU_SLT: begin
                result = '0;
                result[0] = $signed(a) < $signed(b); // signed compare
            end
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ns

module control_unit (
    input  core_pkg::instr_u instr,
    output core_pkg::ctrl_t  ctrl
);

    core_pkg::alu_op_t r_op; // operation picked from funct fields

    always_comb begin
        case (instr.r.funct3)
            3'b000:  r_op = instr.r.funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b010:  r_op = core_pkg::ALU_SLT;
            3'b110:  r_op = core_pkg::ALU_OR;
            3'b111:  r_op = core_pkg::ALU_AND;
            default: r_op = core_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = core_pkg::ALU_ADD;
        case (instr.r.opcode)
            core_pkg::OP_R: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = r_op;
            end
            core_pkg::OP_IMM: begin // addi only
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            core_pkg::OP_LOAD: begin
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            core_pkg::OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            core_pkg::OP_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = core_pkg::ALU_SUB; // equality via zero flag
            end
            default: ; // no-op, nothing written
        endcase
    end

    // a load and a store never share one instruction
    always_comb begin
        assert (!(ctrl.mem_read && ctrl.mem_write))
            else $error("control: mem_read and mem_write both set");
    end

endmodule

// ==== hdl/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// machine word and address width
`define XLEN 32

// program array depth, fetched by pc[9:2]
`define IMEM_WORDS 256

// data memory, indexed by addr[7:2]
`define DMEM_WORDS 64
`define DMEM_AW 6

`endif

// ==== hdl/core_pkg.sv ====
`include "core_params.svh"

package core_pkg;

    typedef logic [`XLEN-1:0] word_t;

    // only the opcodes the core executes, anything else is a no-op
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi; // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo; // imm[4:0]
        opcode_t    opcode;
    } s_fmt_t;

    // branch offset bits are scattered across the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        word_t  raw;
    } instr_u;

    typedef struct packed {
        logic    branch;
        logic    mem_read;
        logic    mem_to_reg;
        logic    mem_write;
        logic    alu_src;
        logic    reg_write;
        alu_op_t alu_op;
    } ctrl_t;

    // one record per executed instruction
    typedef struct packed {
        logic       valid;
        word_t      pc;
        instr_u     instr;
        logic       reg_write;
        logic [4:0] rd;
        word_t      rd_data;
        logic       mem_write;
        word_t      mem_addr;
        word_t      mem_wdata;
    } retire_t;

endpackage

// ==== hdl/core_top.sv ====
`timescale 1ns/1ns

module core_top (
    input  logic              CLK,
    input  logic              RESET_N,
    output core_pkg::word_t   imem_addr,
    input  core_pkg::instr_u  imem_data,
    output core_pkg::retire_t retire
);

    core_pkg::word_t pc;
    logic            valid; // first edge after reset is a bubble
    core_pkg::ctrl_t ctrl;

    core_pkg::word_t rs1_data;
    core_pkg::word_t rs2_data;
    core_pkg::word_t imm;
    core_pkg::word_t alu_b;
    core_pkg::word_t alu_result;
    logic            alu_zero;
    core_pkg::word_t load_data;
    core_pkg::word_t wb_data;

    core_pkg::word_t pc_plus4;
    core_pkg::word_t branch_target;
    logic            take_branch;
    core_pkg::word_t next_pc;

    logic reg_we;
    logic mem_we;

    assign imem_addr = pc;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            valid <= 1'b0;
        end else begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else if (valid) begin
            pc <= next_pc;
        end
    end

    // no state changes until the core is running
    assign reg_we = ctrl.reg_write & valid;
    assign mem_we = ctrl.mem_write & valid;

    control_unit u_ctrl (
        .instr (imem_data),
        .ctrl  (ctrl)
    );

    register_file u_regs (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .rs1       (imem_data.r.rs1),
        .rs2       (imem_data.r.rs2),
        .rd        (imem_data.r.rd),
        .rd_data   (wb_data),
        .reg_write (reg_we),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    imm_gen u_imm (
        .instr (imem_data),
        .imm   (imm)
    );

    assign alu_b = ctrl.alu_src ? imm : rs2_data;

    alu u_alu (
        .a      (rs1_data),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    data_memory u_dmem (
        .CLK       (CLK),
        .mem_write (mem_we),
        .mem_read  (ctrl.mem_read),
        .addr      (alu_result),
        .wdata     (rs2_data),
        .rdata     (load_data)
    );

    assign wb_data = ctrl.mem_to_reg ? load_data : alu_result;

    // next pc
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc + imm;
    assign take_branch   = ctrl.branch & alu_zero;
    assign next_pc       = take_branch ? branch_target : pc_plus4;

    // unused write fields read as zero so every record has one form
    always_comb begin
        retire           = '0;
        retire.valid     = valid;
        retire.pc        = pc;
        retire.instr     = imem_data;
        retire.reg_write = reg_we;
        retire.mem_write = mem_we;
        if (reg_we) begin
            retire.rd      = imem_data.r.rd;
            retire.rd_data = wb_data;
        end
        if (mem_we) begin
            retire.mem_addr  = alu_result;
            retire.mem_wdata = rs2_data;
        end
    end

endmodule

// ==== hdl/data_memory.sv ====
`timescale 1ns/1ns
`include "core_params.svh"

module data_memory (
    input  logic            CLK,
    input  logic            mem_write,
    input  logic            mem_read,
    input  core_pkg::word_t addr,
    input  core_pkg::word_t wdata,
    output core_pkg::word_t rdata
);

    core_pkg::word_t mem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] idx;

    assign idx = addr[`DMEM_AW+1:2]; // word index, upper bits ignored

    always_ff @(posedge CLK) begin
        if (mem_write) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem_read ? mem[idx] : '0;

    // word access only
    a_aligned_write: assert property (
        @(posedge CLK) mem_write |-> (addr[1:0] == 2'b00)
    ) else $error("dmem: misaligned write to %h", addr);

endmodule

// ==== hdl/imm_gen.sv ====
`timescale 1ns/1ns
`include "core_params.svh"

module imm_gen (
    input  core_pkg::instr_u instr,
    output core_pkg::word_t  imm
);

    always_comb begin
        case (instr.r.opcode)
            core_pkg::OP_IMM,
            core_pkg::OP_LOAD: begin
                imm = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            end
            core_pkg::OP_STORE: begin
                imm = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            core_pkg::OP_BRANCH: begin
                // 13 bit offset, lsb always zero
                imm = {{(`XLEN-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            default: imm = '0; // r-type and unknown
        endcase
    end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ns

module register_file (
    input  logic            CLK,
    input  logic            RESET_N,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  core_pkg::word_t rd_data,
    input  logic            reg_write,
    output core_pkg::word_t rs1_data,
    output core_pkg::word_t rs2_data
);

    core_pkg::word_t regs [32];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (reg_write && rd != 5'd0) begin
            regs[rd] <= rd_data;
        end
    end

    // x0 storage cleared by reset and never written
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 must read zero on both ports
    a_x0_zero: assert property (
        @(posedge CLK) disable iff (!RESET_N)
        (rs1 != 5'd0 || rs1_data == '0) && (rs2 != 5'd0 || rs2_data == '0)
    ) else $error("regfile: x0 read back nonzero");

endmodule

// ==== riscv_core.f ====
+incdir+hdl
+incdir+test
hdl/core_pkg.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/imm_gen.sv
hdl/alu.sv
hdl/data_memory.sv
hdl/core_top.sv
test/core_tb.sv

// ==== test/core_model.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// architectural state of the reference model
core_pkg::word_t m_regs [32];
core_pkg::word_t m_mem [`DMEM_WORDS];
core_pkg::word_t m_pc;

function automatic core_pkg::word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic void model_reset();
    for (int k = 0; k < 32; k++) begin
        m_regs[k] = '0;
    end
    m_pc = '0;
endfunction

// what the core shows while held in reset or in its bubble cycle
function automatic core_pkg::retire_t idle_record(input core_pkg::word_t iw);
    core_pkg::retire_t r;
    r = '0;
    r.instr.raw = iw;
    return r;
endfunction

// execute one instruction, return the expected retire record
function automatic core_pkg::retire_t model_step(input core_pkg::word_t iw);
    core_pkg::retire_t r;
    core_pkg::word_t   a;
    core_pkg::word_t   b;
    core_pkg::word_t   addr;
    core_pkg::word_t   next_pc;
    logic [4:0]        rd;
    r = '0;
    r.valid = 1'b1;
    r.pc = m_pc;
    r.instr.raw = iw;
    rd = iw[11:7];
    a = m_regs[iw[19:15]];
    b = m_regs[iw[24:20]];
    next_pc = m_pc + 32'd4;
    case (iw[6:0])
        7'b0110011: begin
            r.reg_write = 1'b1;
            case (iw[14:12])
                3'b010:  r.rd_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b110:  r.rd_data = a | b;
                3'b111:  r.rd_data = a & b;
                default: r.rd_data = iw[30] ? a - b : a + b; // add or sub
            endcase
        end
        7'b0010011: begin
            r.reg_write = 1'b1;
            r.rd_data = a + sext12(iw[31:20]);
        end
        7'b0000011: begin
            addr = a + sext12(iw[31:20]);
            r.reg_write = 1'b1;
            r.rd_data = m_mem[addr[`DMEM_AW+1:2]];
        end
        7'b0100011: begin
            addr = a + sext12({iw[31:25], iw[11:7]});
            r.mem_write = 1'b1;
            r.mem_addr = addr;
            r.mem_wdata = b;
            m_mem[addr[`DMEM_AW+1:2]] = b;
        end
        7'b1100011: begin
            if (a == b) begin
                next_pc = m_pc + {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
            end
        end
        default: ; // anything else just moves on
    endcase
    if (r.reg_write) begin
        r.rd = rd;
        if (rd != 5'd0) begin
            m_regs[rd] = r.rd_data;
        end
    end
    m_pc = next_pc;
    return r;
endfunction

`endif

// ==== test/core_tb.sv ====
`timescale 1ns/1ns
`include "core_params.svh"

module core_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int RUN_CYCLES   = 200;
    localparam int NUM_TESTS    = 6;
    localparam int WATCHDOG_NS  = NUM_TESTS * (RUN_CYCLES + RESET_CYCLES) * CLK_PERIOD * 2;

    logic              CLK;
    logic              RESET_N;
    core_pkg::word_t   imem_addr;
    core_pkg::instr_u  imem_data;
    core_pkg::retire_t retire;

    core_pkg::word_t prog [`IMEM_WORDS];
    int              n_checks;
    int              n_errors;

    `include "core_model.svh"

    core_top uut (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire)
    );

    assign imem_data = prog[imem_addr[9:2]]; // same-cycle fetch, wraps

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    function automatic core_pkg::word_t r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic core_pkg::word_t i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic core_pkg::word_t store_word(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic core_pkg::word_t branch_word(input logic [12:0] imm,
            input logic [4:0] rs2, input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [4:0] pick_reg(input int lo, input int hi);
        return 5'($urandom_range(hi, lo));
    endfunction

    function automatic core_pkg::word_t random_alu(input bit zero_bias);
        int         pick;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        pick = $urandom_range(0, 7);
        rd = pick_reg(0, 31);
        rs1 = pick_reg(0, 31);
        rs2 = pick_reg(0, 31);
        if (zero_bias) begin // aim writes at x0, then read it back
            if ($urandom_range(0, 1) == 1) rd = 5'd0;
            if ($urandom_range(0, 2) == 0) rs1 = 5'd0;
            if ($urandom_range(0, 2) == 0) rs2 = 5'd0;
        end
        case (pick)
            0: return r_type_word(7'h00, rs2, rs1, 3'b000, rd);
            1: return r_type_word(7'h20, rs2, rs1, 3'b000, rd);
            2: return r_type_word(7'h00, rs2, rs1, 3'b010, rd);
            3: return r_type_word(7'h00, rs2, rs1, 3'b110, rd);
            4: return r_type_word(7'h00, rs2, rs1, 3'b111, rd);
            default: return i_type_word(12'($urandom), rs1, 3'b000, rd, 7'b0010011);
        endcase
    endfunction

    // x0 base, word offsets in the low 16 words so addresses repeat
    function automatic core_pkg::word_t random_mem();
        logic [11:0] off;
        off = 12'(4 * $urandom_range(0, 15));
        if ($urandom_range(0, 1) == 1) begin
            return store_word(off, pick_reg(0, 31), 5'd0);
        end
        return i_type_word(off, 5'd0, 3'b010, pick_reg(0, 31), 7'b0000011);
    endfunction

    function automatic core_pkg::word_t small_addi();
        int v;
        v = int'($urandom_range(0, 4)) - 2;
        return i_type_word(12'(v), pick_reg(0, 3), 3'b000, pick_reg(1, 3), 7'b0010011);
    endfunction

    function automatic core_pkg::word_t random_branch();
        int off;
        off = 4 * int'($urandom_range(1, 16)); // up to 64 bytes either way
        if ($urandom_range(0, 1) == 1) off = -off;
        return branch_word(13'(off), pick_reg(0, 3), pick_reg(0, 3));
    endfunction

    function automatic core_pkg::word_t random_illegal();
        core_pkg::word_t w;
        logic [6:0]      op;
        w = $urandom;
        op = w[6:0];
        while (op == 7'b0110011 || op == 7'b0010011 || op == 7'b0000011 ||
               op == 7'b0100011 || op == 7'b1100011) begin
            op = 7'($urandom);
        end
        w[6:0] = op;
        return w;
    endfunction

    function automatic core_pkg::word_t random_instr(input int t);
        int pick;
        pick = $urandom_range(0, 9);
        case (t)
            0: return (pick < 5) ? random_alu(1'b0) : (pick < 7) ? random_mem() : random_branch();
            1: return random_alu(1'b0);
            2: return random_alu(1'b1);
            3: return (pick < 8) ? random_mem() : random_alu(1'b0);
            4: return (pick < 5) ? random_branch() : small_addi();
            default: return (pick < 4) ? random_illegal() : (pick < 7) ? small_addi() : random_mem();
        endcase
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0: return "reset";
            1: return "alu_ops";
            2: return "x0_zero";
            3: return "load_store";
            4: return "branch";
            default: return "illegal_nop";
        endcase
    endfunction

    // straight-line stores first so every data word is known before a load
    task automatic load_program(input int t);
        for (int k = 0; k < `IMEM_WORDS; k++) begin
            if (k < `DMEM_WORDS) begin
                prog[k] = store_word(12'(4 * k), 5'd0, 5'd0);
            end else begin
                prog[k] = random_instr(t);
            end
        end
    endtask

    task automatic check_retire(input string name, input core_pkg::retire_t exp,
            input core_pkg::retire_t act);
        n_checks = n_checks + 1;
        if (act !== exp) begin
            n_errors = n_errors + 1;
            $display("FAILED %s retire at %0t: expected %h, actual %h", name, $time, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input core_pkg::word_t exp,
            input core_pkg::word_t act);
        n_checks = n_checks + 1;
        if (act !== exp) begin
            n_errors = n_errors + 1;
            $display("FAILED %s pc at %0t: expected %h, actual %h", name, $time, exp, act);
        end
    endtask

    task automatic run_test(input int t);
        string             name;
        int                c0;
        int                e0;
        core_pkg::retire_t exp;
        name = test_name(t);
        c0 = n_checks;
        e0 = n_errors;
        @(posedge CLK);
        #1;
        RESET_N = 1'b0;
        load_program(t);
        model_reset();
        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            check_retire(name, idle_record(prog[0]), retire);
            @(posedge CLK);
        end
        #1;
        RESET_N = 1'b1;
        @(negedge CLK);
        check_retire(name, idle_record(prog[0]), retire); // bubble before first retire
        repeat (RUN_CYCLES) begin
            @(negedge CLK);
            check_pc(name, m_pc, imem_addr);
            exp = model_step(prog[m_pc[9:2]]);
            check_retire(name, exp, retire);
        end
        $display("test %s: %0d checks, %0d mismatches", name, n_checks - c0, n_errors - e0);
    endtask

    initial begin
        void'($urandom(32'hf96c));
        n_checks = 0;
        n_errors = 0;
        RESET_N = 1'b0;
        for (int k = 0; k < `IMEM_WORDS; k++) begin
            prog[k] = i_type_word(12'(k), 5'd0, 3'b000, 5'd0, 7'b0010011);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests %0d, checks %0d, mismatches %0d", NUM_TESTS, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
